/* source/engine_defs.svh */
`ifndef ENGINE_DEFS_SVH
`define ENGINE_DEFS_SVH

// Sample and address widths
`define ENGINE_DATA_W 16
`define ENGINE_ADDR_W 30

// Accumulator wide enough for a full Q16.16 product sum
`define ENGINE_ACC_W 32

// Kernel size and output count fields
`define ENGINE_LEN_W 8
`define ENGINE_STRIDE_W 4

// Stream buffers
`define ENGINE_FIFO_DEPTH 8
`define ENGINE_CNT_W 4

`endif

/* source/engine_pkg.sv */
`default_nettype none

package engine_pkg;

	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_CMAC = 3'd1,
		OP_SCMP = 3'd2,
		OP_SACC = 3'd3
	} op_t;

	// Q8.8 signed sample
	typedef logic signed [15:0] sample_t;

	// DMA word address
	typedef logic [29:0] addr_t;

	// One result on its way to the p0 write port
	typedef struct packed {
		addr_t   addr;
		sample_t value;
	} wr_entry_t;

endpackage

`default_nettype wire

/* source/engine_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module engine_ctrl import engine_pkg::*; (
	input  wire logic clk,
	input  wire logic i_rst_n,
	input  wire logic i_engine_valid,
	input  wire op_t  i_op_type,
	input  wire logic i_issue_last,
	input  wire logic i_result_done,
	input  wire logic i_out_empty,
	output logic      o_issue_en,
	output logic      o_start,
	output logic      o_engine_ready
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RUN,
		S_DRAIN,
		S_DONE,
		S_WAIT_LOW
	} state_t;

	state_t state;
	logic   result_seen;
	logic   op_ok;

	assign op_ok = (i_op_type == OP_CMAC) || (i_op_type == OP_SCMP) ||
		(i_op_type == OP_SACC);

	// Start clears counters and the PE while the FSM enters RUN
	assign o_start = (state == S_IDLE) && i_engine_valid;
	assign o_issue_en = (state == S_RUN);
	assign o_engine_ready = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			result_seen <= 1'b0;
		end else begin
			// Last result may show up before the buffer drains
			if (o_start)
				result_seen <= 1'b0;
			else if (i_result_done)
				result_seen <= 1'b1;

			case (state)
				S_IDLE: begin
					if (i_engine_valid)
						state <= op_ok ? S_RUN : S_DONE;
				end
				S_RUN: begin
					if (i_issue_last)
						state <= S_DRAIN;
				end
				S_DRAIN: begin
					if (result_seen && i_out_empty)
						state <= S_DONE;
				end
				S_DONE: begin
					state <= S_WAIT_LOW;
				end
				S_WAIT_LOW: begin
					// Host must drop valid before the next op
					if (!i_engine_valid)
						state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	a_ready_when_drained: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_engine_ready |-> i_out_empty);

endmodule

`default_nettype wire

/* source/engine_counter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module engine_counter (
	input  wire logic                     clk,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_clear,
	input  wire logic                     i_step,
	input  wire logic [`ENGINE_LEN_W-1:0] i_kernel_size,
	input  wire logic [`ENGINE_LEN_W-1:0] i_o_count,
	output logic      [`ENGINE_LEN_W-1:0] o_k,
	output logic      [`ENGINE_LEN_W-1:0] o_o,
	output logic                          o_last_k,
	output logic                          o_last
);

	logic [`ENGINE_LEN_W-1:0] k_q;
	logic [`ENGINE_LEN_W-1:0] o_q;
	logic                     finished;

	assign o_k = k_q;
	assign o_o = o_q;
	assign o_last_k = (k_q == i_kernel_size - 1'b1);
	assign o_last = o_last_k && (o_q == i_o_count - 1'b1);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			k_q <= '0;
			o_q <= '0;
			finished <= 1'b0;
		end else if (i_clear) begin
			k_q <= '0;
			o_q <= '0;
			finished <= 1'b0;
		end else if (i_step && !finished) begin
			// Holds on the final position until cleared
			if (o_last) begin
				finished <= 1'b1;
			end else if (o_last_k) begin
				k_q <= '0;
				o_q <= o_q + 1'b1;
			end else begin
				k_q <= k_q + 1'b1;
			end
		end
	end

	a_no_step_past_end: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_step |-> !finished);

endmodule

`default_nettype wire

/* source/sample_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module sample_fifo import engine_pkg::*; #(
	parameter type payload_t = sample_t
) (
	input  wire logic                     clk,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_push,
	input  wire payload_t                 i_data,
	input  wire logic                     i_pop,
	output payload_t                      o_data,
	output logic                          o_empty,
	output logic                          o_full,
	output logic      [`ENGINE_CNT_W-1:0] o_count
);

	localparam int DEPTH = `ENGINE_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_data = mem[rd_ptr];
	assign o_empty = (o_count == '0);
	assign o_full = (o_count == DEPTH);

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			o_count <= o_count + do_push - do_pop;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_push |-> !o_full);

	a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

/* source/engine_pe.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module engine_pe import engine_pkg::*; (
	input  wire logic    clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_clear,
	input  wire op_t     i_op_type,
	input  wire sample_t i_data,
	input  wire sample_t i_weight,
	input  wire logic    i_consume,
	input  wire logic    i_last_k,
	output sample_t      o_result,
	output logic         o_result_valid
);

	localparam int FRAC_W = 8;
	localparam int SAT_MAX = 2 ** (`ENGINE_DATA_W - 1) - 1;
	localparam int SAT_MIN = -(2 ** (`ENGINE_DATA_W - 1));

	logic signed [`ENGINE_ACC_W-1:0] acc;
	logic signed [`ENGINE_ACC_W-1:0] base;
	logic signed [`ENGINE_ACC_W-1:0] data_ext;
	logic signed [`ENGINE_ACC_W-1:0] prod;
	logic signed [`ENGINE_ACC_W-1:0] acc_next;
	logic signed [`ENGINE_ACC_W-1:0] win_val;
	logic                            first;

	function automatic sample_t saturate(input logic signed [`ENGINE_ACC_W-1:0] v);
		if (v > SAT_MAX)
			return sample_t'(SAT_MAX);
		if (v < SAT_MIN)
			return sample_t'(SAT_MIN);
		return sample_t'(v);
	endfunction

	// Full Q16.16 product rescaled once at the end of the window
	assign prod = i_data * i_weight;
	assign data_ext = i_data;
	assign base = first ? '0 : acc;

	always_comb begin
		case (i_op_type)
			OP_CMAC: acc_next = base + prod;
			OP_SACC: acc_next = base + data_ext;
			OP_SCMP: begin
				if (first || (data_ext > acc))
					acc_next = data_ext;
				else
					acc_next = acc;
			end
			default: acc_next = acc;
		endcase
	end

	assign win_val = (i_op_type == OP_CMAC) ? (acc_next >>> FRAC_W) : acc_next;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			first <= 1'b1;
			o_result_valid <= 1'b0;
		end else if (i_clear) begin
			first <= 1'b1;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_consume && i_last_k;
			// Next element after the last one opens a new window
			if (i_consume)
				first <= i_last_k;
		end
	end

	always_ff @(posedge clk) begin
		if (i_consume)
			acc <= acc_next;
		if (i_consume && i_last_k)
			o_result <= saturate(win_val);
	end

endmodule

`default_nettype wire

/* source/engine.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module engine import engine_pkg::*; (
	input  wire logic                        clk,
	input  wire logic                        i_rst_n,
	input  wire logic                        i_engine_valid,
	input  wire op_t                         i_op_type,
	input  wire logic [`ENGINE_STRIDE_W-1:0] i_stride,
	input  wire logic [`ENGINE_LEN_W-1:0]    i_kernel_size,
	input  wire logic [`ENGINE_LEN_W-1:0]    i_o_count,
	input  wire addr_t                       i_data_start_addr,
	input  wire addr_t                       i_weight_start_addr,
	input  wire addr_t                       i_result_start_addr,
	input  wire sample_t                     i_dma_p2_ob_data,
	input  wire sample_t                     i_dma_p3_ob_data,
	input  wire logic                        i_dma_p2_ob_we,
	input  wire logic                        i_dma_p3_ob_we,
	input  wire logic                        i_dma_p0_ib_re,
	output logic                             o_engine_ready,
	output logic                             o_dma_p2_reads_en,
	output logic                             o_dma_p3_reads_en,
	output addr_t                            o_p2_addr,
	output addr_t                            o_p3_addr,
	output logic                             o_dma_p0_writes_en,
	output addr_t                            o_p0_addr,
	output sample_t                          o_dma_p0_ib_data
);

	localparam int DEPTH = `ENGINE_FIFO_DEPTH;

	logic                                            start;
	logic                                            issue_en;
	logic                                            issue_fire;
	logic                                            issue_last;
	logic [`ENGINE_LEN_W-1:0]                        issue_k;
	logic [`ENGINE_LEN_W-1:0]                        issue_o;
	logic [`ENGINE_LEN_W+`ENGINE_STRIDE_W-1:0]       win_base;
	logic                                            is_cmac;
	logic [`ENGINE_CNT_W-1:0]                        p2_inflight;
	logic [`ENGINE_CNT_W-1:0]                        p3_inflight;
	logic                                            p2_credit_ok;
	logic                                            p3_credit_ok;
	sample_t                                         data_head;
	sample_t                                         weight_head;
	logic                                            data_empty;
	logic                                            weight_empty;
	logic [`ENGINE_CNT_W-1:0]                        data_count;
	logic [`ENGINE_CNT_W-1:0]                        weight_count;
	logic                                            consume;
	logic                                            cons_last_k;
	logic                                            cons_last;
	logic                                            last_consumed;
	logic                                            out_room;
	logic                                            out_empty;
	logic [`ENGINE_CNT_W-1:0]                        out_count;
	sample_t                                         pe_result;
	logic                                            pe_result_valid;
	logic [`ENGINE_LEN_W-1:0]                        res_n;
	wr_entry_t                                       res_entry;
	wr_entry_t                                       out_head;

	engine_ctrl u_ctrl (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_engine_valid (i_engine_valid),
		.i_op_type      (i_op_type),
		.i_issue_last   (issue_fire && issue_last),
		.i_result_done  (pe_result_valid && last_consumed),
		.i_out_empty    (out_empty),
		.o_issue_en     (issue_en),
		.o_start        (start),
		.o_engine_ready (o_engine_ready)
	);

	assign is_cmac = (i_op_type == OP_CMAC);

	// Credit covers words in flight plus words already buffered
	assign p2_credit_ok = (p2_inflight + data_count) < DEPTH;
	assign p3_credit_ok = (p3_inflight + weight_count) < DEPTH;
	assign issue_fire = issue_en && p2_credit_ok && (!is_cmac || p3_credit_ok);

	assign o_dma_p2_reads_en = issue_fire;
	assign o_dma_p3_reads_en = issue_fire && is_cmac;

	engine_counter u_issue_cnt (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_clear       (start),
		.i_step        (issue_fire),
		.i_kernel_size (i_kernel_size),
		.i_o_count     (i_o_count),
		.o_k           (issue_k),
		.o_o           (issue_o),
		.o_last_k      (),
		.o_last        (issue_last)
	);

	// Window base for output o is o * stride words past the data start
	assign win_base = issue_o * i_stride;
	assign o_p2_addr = i_data_start_addr + addr_t'(win_base) + addr_t'(issue_k);
	assign o_p3_addr = i_weight_start_addr + addr_t'(issue_k);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			p2_inflight <= '0;
			p3_inflight <= '0;
		end else begin
			p2_inflight <= p2_inflight + o_dma_p2_reads_en - i_dma_p2_ob_we;
			p3_inflight <= p3_inflight + o_dma_p3_reads_en - i_dma_p3_ob_we;
		end
	end

	sample_fifo #(.payload_t(sample_t)) u_data_fifo (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_push  (i_dma_p2_ob_we),
		.i_data  (i_dma_p2_ob_data),
		.i_pop   (consume),
		.o_data  (data_head),
		.o_empty (data_empty),
		.o_full  (),
		.o_count (data_count)
	);

	sample_fifo #(.payload_t(sample_t)) u_weight_fifo (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_push  (i_dma_p3_ob_we),
		.i_data  (i_dma_p3_ob_data),
		.i_pop   (consume && is_cmac),
		.o_data  (weight_head),
		.o_empty (weight_empty),
		.o_full  (),
		.o_count (weight_count)
	);

	// Leave a slot for a result that is still being registered
	assign out_room = (out_count + pe_result_valid) < DEPTH;
	assign consume = !data_empty && (!is_cmac || !weight_empty) && out_room;

	engine_counter u_cons_cnt (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_clear       (start),
		.i_step        (consume),
		.i_kernel_size (i_kernel_size),
		.i_o_count     (i_o_count),
		.o_k           (),
		.o_o           (),
		.o_last_k      (cons_last_k),
		.o_last        (cons_last)
	);

	engine_pe u_pe (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_clear        (start),
		.i_op_type      (i_op_type),
		.i_data         (data_head),
		.i_weight       (weight_head),
		.i_consume      (consume),
		.i_last_k       (cons_last_k),
		.o_result       (pe_result),
		.o_result_valid (pe_result_valid)
	);

	// Lines up with the PE result of the final window
	always_ff @(posedge clk) begin
		if (!i_rst_n)
			last_consumed <= 1'b0;
		else
			last_consumed <= consume && cons_last;
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			res_n <= '0;
		else if (start)
			res_n <= '0;
		else if (pe_result_valid)
			res_n <= res_n + 1'b1;
	end

	assign res_entry = '{addr: i_result_start_addr + addr_t'(res_n), value: pe_result};

	sample_fifo #(.payload_t(wr_entry_t)) u_out_fifo (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_push  (pe_result_valid),
		.i_data  (res_entry),
		.i_pop   (i_dma_p0_ib_re),
		.o_data  (out_head),
		.o_empty (out_empty),
		.o_full  (),
		.o_count (out_count)
	);

	assign o_dma_p0_writes_en = !out_empty;
	assign o_p0_addr = out_head.addr;
	assign o_dma_p0_ib_data = out_head.value;

	a_p2_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dma_p2_ob_we |-> (p2_inflight != '0));

	a_p3_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_dma_p3_ob_we |-> (p3_inflight != '0));

endmodule

`default_nettype wire

/* bench/engine_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "engine_defs.svh"

module engine_tb import engine_pkg::*; ();

	// Window elements summed over all tests plus one spare for the unsupported ops
	localparam int ELEMENTS = 36 + 20 + 24 + 80 + 1 + 17;
	localparam int WATCHDOG_CYCLES = 200 * ELEMENTS + 100;

	logic                        clk = 1'b0;
	logic                        i_rst_n;
	logic                        i_engine_valid;
	op_t                         i_op_type;
	logic [`ENGINE_STRIDE_W-1:0] i_stride;
	logic [`ENGINE_LEN_W-1:0]    i_kernel_size;
	logic [`ENGINE_LEN_W-1:0]    i_o_count;
	addr_t                       i_data_start_addr;
	addr_t                       i_weight_start_addr;
	addr_t                       i_result_start_addr;
	sample_t                     p2_data = '0;
	sample_t                     p3_data = '0;
	logic                        p2_we = 1'b0;
	logic                        p3_we = 1'b0;
	logic                        p0_re = 1'b0;
	logic                        o_engine_ready;
	logic                        o_dma_p2_reads_en;
	logic                        o_dma_p3_reads_en;
	addr_t                       o_p2_addr;
	addr_t                       o_p3_addr;
	logic                        o_dma_p0_writes_en;
	addr_t                       o_p0_addr;
	sample_t                     o_dma_p0_ib_data;

	sample_t   mem [addr_t];
	addr_t     p2_pend[$];
	addr_t     p3_pend[$];
	int        p2_due[$];
	int        p3_due[$];
	addr_t     p2_seen[$];
	addr_t     p3_seen[$];
	int        ready_cycles;
	wr_entry_t results[$];
	wr_entry_t taken;
	int        read_pace = 70;
	int        cyc = 0;
	int        errors;
	int        tests_passed;
	int        tests_failed;

	engine dut (
		.clk                 (clk),
		.i_rst_n             (i_rst_n),
		.i_engine_valid      (i_engine_valid),
		.i_op_type           (i_op_type),
		.i_stride            (i_stride),
		.i_kernel_size       (i_kernel_size),
		.i_o_count           (i_o_count),
		.i_data_start_addr   (i_data_start_addr),
		.i_weight_start_addr (i_weight_start_addr),
		.i_result_start_addr (i_result_start_addr),
		.i_dma_p2_ob_data    (p2_data),
		.i_dma_p3_ob_data    (p3_data),
		.i_dma_p2_ob_we      (p2_we),
		.i_dma_p3_ob_we      (p3_we),
		.i_dma_p0_ib_re      (p0_re),
		.o_engine_ready      (o_engine_ready),
		.o_dma_p2_reads_en   (o_dma_p2_reads_en),
		.o_dma_p3_reads_en   (o_dma_p3_reads_en),
		.o_p2_addr           (o_p2_addr),
		.o_p3_addr           (o_p3_addr),
		.o_dma_p0_writes_en  (o_dma_p0_writes_en),
		.o_p0_addr           (o_p0_addr),
		.o_dma_p0_ib_data    (o_dma_p0_ib_data)
	);

	always #5 clk = ~clk;

	function automatic sample_t read_mem(addr_t a);
		if (mem.exists(a))
			return mem[a];
		return sample_t'(a[15:0] ^ a[29:14]);
	endfunction

	function automatic sample_t clamp_sample(longint v);
		if (v > 32767)
			return 16'sh7fff;
		if (v < -32768)
			return 16'sh8000;
		return sample_t'(v);
	endfunction

	// Reference result for output n from the window rule
	function automatic sample_t expected_result(op_t op, addr_t dstart, addr_t wstart,
			int stride, int k, int n);
		longint acc;
		longint d;
		int     i;
		acc = 0;
		for (i = 0; i < k; i++) begin
			d = read_mem(dstart + addr_t'(n * stride + i));
			if (op == OP_CMAC)
				acc += d * longint'(read_mem(wstart + addr_t'(i)));
			else if (op == OP_SACC)
				acc += d;
			else if (i == 0 || d > acc)
				acc = d;
		end
		if (op == OP_CMAC)
			acc = acc >>> 8;
		return clamp_sample(acc);
	endfunction

	// DMA model driven on the falling edge
	always @(negedge clk) begin
		cyc++;
		p2_we = 1'b0;
		p3_we = 1'b0;
		// Words go back in request order once their latency has run out
		if (p2_pend.size() > 0 && p2_due[0] <= cyc) begin
			p2_data = read_mem(p2_pend.pop_front());
			void'(p2_due.pop_front());
			p2_we = 1'b1;
		end
		if (p3_pend.size() > 0 && p3_due[0] <= cyc) begin
			p3_data = read_mem(p3_pend.pop_front());
			void'(p3_due.pop_front());
			p3_we = 1'b1;
		end
		if (o_dma_p2_reads_en) begin
			p2_pend.push_back(o_p2_addr);
			p2_due.push_back(cyc + int'($urandom_range(4, 1)));
			p2_seen.push_back(o_p2_addr);
		end
		if (o_dma_p3_reads_en) begin
			p3_pend.push_back(o_p3_addr);
			p3_due.push_back(cyc + int'($urandom_range(4, 1)));
			p3_seen.push_back(o_p3_addr);
		end
		if (o_engine_ready)
			ready_cycles++;
		p0_re = 1'b0;
		if (o_dma_p0_writes_en && ($urandom_range(99, 0) < read_pace)) begin
			taken.addr = o_p0_addr;
			taken.value = o_dma_p0_ib_data;
			results.push_back(taken);
			p0_re = 1'b1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before all tests finished");
		$display("Test FAILED");
		$finish;
	end

	task automatic check_sample(string name, sample_t got, sample_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic fill_random(addr_t start, int count, int lo, int hi);
		int i;
		for (i = 0; i < count; i++)
			mem[start + addr_t'(i)] = sample_t'(int'($urandom_range(hi - lo, 0)) + lo);
	endtask

	task automatic fill_const(addr_t start, int count, sample_t value);
		int i;
		for (i = 0; i < count; i++)
			mem[start + addr_t'(i)] = value;
	endtask

	// One full operation from valid to ready and the checks on what was seen
	task automatic run_op(op_t op, int stride, int k, int n, addr_t dstart, addr_t wstart,
			addr_t rstart, int pace);
		int   idx;
		int   elems;
		logic ok;
		ok = (op == OP_CMAC) || (op == OP_SCMP) || (op == OP_SACC);
		elems = ok ? k * n : 0;
		@(negedge clk);
		p2_seen.delete();
		p3_seen.delete();
		results.delete();
		ready_cycles = 0;
		read_pace = pace;
		i_op_type = op;
		i_stride = stride[`ENGINE_STRIDE_W-1:0];
		i_kernel_size = k[`ENGINE_LEN_W-1:0];
		i_o_count = n[`ENGINE_LEN_W-1:0];
		i_data_start_addr = dstart;
		i_weight_start_addr = wstart;
		i_result_start_addr = rstart;
		i_engine_valid = 1'b1;
		do
			@(negedge clk);
		while (!o_engine_ready);
		check_count("o_dma_p0_writes_en at ready", o_dma_p0_writes_en, 0);
		check_count("results taken at ready", results.size(), ok ? n : 0);
		@(negedge clk);
		i_engine_valid = 1'b0;
		repeat (3) @(negedge clk);
		check_count("o_engine_ready cycles", ready_cycles, 1);
		check_count("p2 requests", p2_seen.size(), elems);
		check_count("p3 requests", p3_seen.size(), (op == OP_CMAC) ? elems : 0);
		for (idx = 0; idx < p2_seen.size(); idx++)
			check_addr("o_p2_addr", p2_seen[idx],
				dstart + addr_t'((idx / k) * stride + idx % k));
		for (idx = 0; idx < p3_seen.size(); idx++)
			check_addr("o_p3_addr", p3_seen[idx], wstart + addr_t'(idx % k));
		for (idx = 0; idx < results.size(); idx++) begin
			check_addr("o_p0_addr", results[idx].addr, rstart + addr_t'(idx));
			check_sample("o_dma_p0_ib_data", results[idx].value,
				expected_result(op, dstart, wstart, stride, k, idx));
		end
	endtask

	task automatic report_test(string name);
		if (errors == 0) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", name, errors);
			tests_failed++;
		end
	endtask

	task automatic test_idle_and_bad_op();
		errors = 0;
		check_count("o_dma_p2_reads_en", o_dma_p2_reads_en, 0);
		check_count("o_dma_p3_reads_en", o_dma_p3_reads_en, 0);
		check_count("o_dma_p0_writes_en", o_dma_p0_writes_en, 0);
		check_count("o_engine_ready", o_engine_ready, 0);
		run_op(op_t'(3'd5), 1, 4, 2, 30'd0, 30'd0, 30'd900, 100);
		run_op(OP_NONE, 1, 4, 2, 30'd0, 30'd0, 30'd900, 100);
		report_test("idle_and_bad_op");
	endtask

	task automatic test_cmac_dot();
		errors = 0;
		fill_random(30'd100, 12, -2048, 2047);
		fill_random(30'd200, 9, -2048, 2047);
		run_op(OP_CMAC, 1, 9, 4, 30'd100, 30'd200, 30'd300, 70);
		report_test("cmac_dot");
	endtask

	task automatic test_scmp_max();
		errors = 0;
		fill_random(30'd400, 20, -32768, 32767);
		run_op(OP_SCMP, 4, 4, 5, 30'd400, 30'd0, 30'd320, 70);
		report_test("scmp_max");
	endtask

	task automatic test_sacc_saturate();
		errors = 0;
		fill_const(30'd500, 8, 16'sh7000);
		fill_const(30'd508, 8, 16'sh9000);
		fill_random(30'd516, 8, -256, 255);
		run_op(OP_SACC, 8, 8, 3, 30'd500, 30'd0, 30'd340, 70);
		if (results.size() >= 2) begin
			check_sample("saturated high", results[0].value, 16'sh7fff);
			check_sample("saturated low", results[1].value, 16'sh8000);
		end
		report_test("sacc_saturate");
	endtask

	// More results than the result buffer holds, so the slow reader stalls the PE
	task automatic test_stride_overlap();
		errors = 0;
		fill_random(30'd600, 50, -2048, 2047);
		fill_random(30'd700, 5, -2048, 2047);
		run_op(OP_CMAC, 3, 5, 16, 30'd600, 30'd700, 30'd360, 10);
		report_test("stride_overlap");
	endtask

	task automatic test_back_to_back();
		errors = 0;
		fill_random(30'd800, 5, -1024, 1023);
		fill_random(30'd820, 3, -1024, 1023);
		run_op(OP_CMAC, 1, 3, 3, 30'd800, 30'd820, 30'd380, 50);
		fill_random(30'd840, 8, -4096, 4095);
		run_op(OP_SACC, 2, 2, 4, 30'd840, 30'd0, 30'd390, 50);
		report_test("back_to_back");
	endtask

	initial begin
		void'($urandom(9));
		i_rst_n = 1'b0;
		i_engine_valid = 1'b0;
		i_op_type = OP_NONE;
		i_stride = 1;
		i_kernel_size = 1;
		i_o_count = 1;
		i_data_start_addr = '0;
		i_weight_start_addr = '0;
		i_result_start_addr = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (10) @(negedge clk);
		i_rst_n = 1'b1;
		@(negedge clk);
		test_idle_and_bad_op();
		test_cmac_dot();
		test_scmp_max();
		test_sacc_saturate();
		test_stride_overlap();
		test_back_to_back();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/engine_pkg.sv
source/engine_ctrl.sv
source/engine_counter.sv
source/sample_fifo.sv
source/engine_pe.sv
source/engine.sv
bench/engine_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module engine_tb -f all.f -o engine_sim &&
out="$(./obj_dir/engine_sim)"; echo "$out";
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
